// ==== Makefile ====
# Verilator build and run of the paging core testbench

VERILATOR ?= verilator
TOP       ?= tb_spec_mem
FILELIST  ?= spec_mem.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== bench/spec_mem_asserts.sv ====
// Reference model of the port latches with 2-cycle write latency; raises $error only, bound to the top
module spec_mem_asserts (
	input logic                    clk_sys,
	input logic                    reset,
	input spec_mem_pkg::model_e    model,
	input spec_port_pkg::cpu_bus_t bus,
	input spec_mem_pkg::mem_req_t  mem,
	input logic                    scr_page,
	input logic [2:0]              border,
	input logic                    ear,
	input logic                    mic
);
	timeunit 1ns;
	timeprecision 100ps;

	int                      fail_count = 0; // Read by the testbench
	spec_mem_pkg::model_e    ref_model;
	spec_port_pkg::port_op_e pend_op;
	spec_port_pkg::port_op_e dec_op;
	logic [7:0]              pend_data;
	logic [7:0]              ref_7ffd;
	logic [7:0]              ref_1ffd;
	logic [7:0]              ref_fe;
	logic                    wr_seen;
	logic                    io_wr;
	logic                    on_plus3;
	logic                    may_page;
	logic [17:0]             exp_addr;
	logic                    exp_rd;
	logic                    exp_we;

	// Flat address from the memory map rules
	function automatic logic [17:0] flat_addr(input logic [15:0] a, input logic [7:0] p7,
		input logic [7:0] p1, input spec_mem_pkg::model_e m);
		logic [2:0] bank;
		logic       rom;
		rom = 1'b0;
		if (m == spec_mem_pkg::MODEL_PLUS3 && p1[0]) begin
			case (p1[2:1])
				2'd0: bank = {1'b0, a[15:14]};
				2'd1: bank = {1'b1, a[15:14]};
				2'd2: bank = (a[15:14] == 2'd3) ? 3'd3 : {1'b1, a[15:14]};
				default: bank = (a[15:14] == 2'd1) ? 3'd7 : {~a[15] | ~a[14], a[15:14]};
			endcase
		end else if (a[15:14] == 2'd0) begin
			rom = 1'b1;
			if (m == spec_mem_pkg::MODEL_48)
				bank = 3'd1; // BASIC ROM
			else if (m == spec_mem_pkg::MODEL_128)
				bank = {2'b00, p7[4]};
			else
				bank = {1'b1, p1[2], p7[4]};
		end else if (a[15:14] == 2'd1) begin
			bank = 3'd5;
		end else if (a[15:14] == 2'd2) begin
			bank = 3'd2;
		end else begin
			bank = (m == spec_mem_pkg::MODEL_48) ? 3'd0 : p7[2:0];
		end
		return {rom, bank, a[13:0]};
	endfunction

	// ==============================
	// Port write model
	// ==============================
	assign io_wr    = !bus.iorq_n && !bus.wr_n && bus.m1_n;
	assign on_plus3 = (ref_model == spec_mem_pkg::MODEL_PLUS3);
	assign may_page = (ref_model != spec_mem_pkg::MODEL_48) && !ref_7ffd[5];
	assign exp_addr = flat_addr(bus.addr, ref_7ffd, ref_1ffd, ref_model);
	assign exp_rd   = !bus.mreq_n && !bus.rd_n;
	assign exp_we   = !bus.mreq_n && !bus.wr_n && !exp_addr[17]; // No writes into ROM

	always_comb begin
		dec_op = spec_port_pkg::OP_NONE;
		if (io_wr && !wr_seen) begin
			if (!bus.addr[0])
				dec_op = spec_port_pkg::OP_ULA;
			else if (may_page && !bus.addr[15] && !bus.addr[1] && (bus.addr[14] || !on_plus3))
				dec_op = spec_port_pkg::OP_7FFD;
			else if (may_page && on_plus3 && bus.addr[15:12] == 4'h1 && !bus.addr[1])
				dec_op = spec_port_pkg::OP_1FFD;
		end
	end

	always_ff @(posedge clk_sys) begin
		pend_data <= bus.dout;
		if (reset) begin
			ref_model <= model;
			wr_seen   <= 1'b0;
			pend_op   <= spec_port_pkg::OP_NONE;
			ref_7ffd  <= '0;
			ref_1ffd  <= '0;
			ref_fe    <= '0;
		end else begin
			wr_seen <= io_wr;
			pend_op <= dec_op; // Lands one edge later
			case (pend_op)
				spec_port_pkg::OP_7FFD: ref_7ffd <= pend_data;
				spec_port_pkg::OP_1FFD: ref_1ffd <= pend_data;
				spec_port_pkg::OP_ULA:  ref_fe   <= pend_data;
				default: ;
			endcase
		end
	end

	// ==============================
	// Checks
	// ==============================
	map_ok: assert property (@(posedge clk_sys) disable iff (reset) mem.addr == exp_addr)
		else begin
			fail_count++;
			$error("mismatch %0t mem.addr dut=%h expected=%h", $time,
				$sampled(mem.addr), $sampled(exp_addr));
		end

	strobe_ok: assert property (@(posedge clk_sys)
		mem.rd == exp_rd && mem.we == exp_we)
		else begin
			fail_count++;
			$error("mismatch %0t mem.rd/we dut=%b%b expected=%b%b", $time,
				$sampled(mem.rd), $sampled(mem.we), $sampled(exp_rd), $sampled(exp_we));
		end

	scr_ok: assert property (@(posedge clk_sys) disable iff (reset) scr_page == ref_7ffd[3])
		else begin
			fail_count++;
			$error("mismatch %0t scr_page dut=%b expected=%b", $time,
				$sampled(scr_page), $sampled(ref_7ffd[3]));
		end

	ula_ok: assert property (@(posedge clk_sys) disable iff (reset)
		{border, ear, mic} == {ref_fe[2:0], ref_fe[4], ref_fe[3]})
		else begin
			fail_count++;
			$error("mismatch %0t border/ear/mic dut=%b expected=%b", $time,
				$sampled({border, ear, mic}), $sampled({ref_fe[2:0], ref_fe[4], ref_fe[3]}));
		end

	// Everything cleared once reset drops
	reset_ok: assert property (@(posedge clk_sys) (!reset && $past(reset))
		|-> (border == 3'd0 && !ear && !mic && !scr_page))
		else begin
			fail_count++;
			$error("outputs not cleared by reset at %0t", $time);
		end

endmodule

bind spec_mem_top spec_mem_asserts u_asserts (.*);

// ==== bench/tb_spec_mem.sv ====
// Stimulus only; checking lives in the bound spec_mem_asserts, which must be compiled in
module tb_spec_mem;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int SETTLE_LIMIT = 20; // Cycles for a port write to land

	logic                    clk_sys;
	logic                    reset;
	spec_mem_pkg::model_e    model;
	spec_port_pkg::cpu_bus_t bus;
	spec_mem_pkg::mem_req_t  mem;
	logic                    scr_page;
	logic [2:0]              border;
	logic                    ear;
	logic                    mic;

	spec_mem_top dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	task automatic stop_with_failure(input string why);
		$display("** FAIL **");
		$fatal(1, "%0t %s", $time, why);
	endtask

	// Assertion errors become a fatal end of run
	always @(negedge clk_sys) begin
		if (dut0.u_asserts.fail_count != 0)
			stop_with_failure("a concurrent assertion failed");
	end

	task automatic bus_idle();
		bus.addr   = 16'h0000;
		bus.dout   = 8'h00;
		bus.mreq_n = 1'b1;
		bus.iorq_n = 1'b1;
		bus.rd_n   = 1'b1;
		bus.wr_n   = 1'b1;
		bus.m1_n   = 1'b1;
	endtask

	task automatic enter_reset(input spec_mem_pkg::model_e m);
		@(negedge clk_sys);
		reset = 1'b1;
		model = m;
		bus_idle();
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
	endtask

	// Held 1 to 3 cycles, then idle so the next write is a fresh edge
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data, input logic m1_n);
		@(negedge clk_sys);
		bus_idle();
		bus.addr   = addr;
		bus.dout   = data;
		bus.iorq_n = 1'b0;
		bus.wr_n   = 1'b0;
		bus.m1_n   = m1_n;
		repeat ($urandom_range(3, 1)) @(negedge clk_sys);
		bus_idle();
	endtask

	task automatic mem_access(input logic [15:0] addr, input logic write);
		@(negedge clk_sys);
		bus_idle();
		bus.addr   = addr;
		bus.dout   = 8'($urandom);
		bus.mreq_n = 1'b0;
		bus.rd_n   = write;
		bus.wr_n   = ~write;
	endtask

	task automatic sweep_slots();
		for (int slot = 0; slot < 4; slot++) begin
			mem_access({2'(slot), 14'($urandom)}, 1'b0);
			mem_access({2'(slot), 14'($urandom)}, 1'b1);
		end
		@(negedge clk_sys);
		bus_idle();
	endtask

	task automatic wait_scr_page(input logic expected);
		int cycles;
		cycles = 0;
		while (scr_page !== expected && cycles < SETTLE_LIMIT) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (scr_page !== expected)
			stop_with_failure("scr_page never took the value written to 7FFD");
	endtask

	// Border from bits 2-0, MIC bit 3, EAR bit 4
	task automatic ula_write(input logic [7:0] data);
		int cycles;
		cycles = 0;
		io_write(16'hFFFE, data, 1'b1);
		while ({border, ear, mic} !== {data[2:0], data[4], data[3]} && cycles < SETTLE_LIMIT) begin
			@(negedge clk_sys);
			cycles++;
		end
		if ({border, ear, mic} !== {data[2:0], data[4], data[3]})
			stop_with_failure("border, ear and mic never followed the FE write");
	endtask

	task automatic random_cycles(input int count);
		logic [15:0] ports [3];
		ports = '{16'h7FFD, 16'h1FFD, 16'h00FE};
		for (int i = 0; i < count; i++) begin
			case ($urandom_range(4, 0))
				0: mem_access(16'($urandom), 1'b0);
				1: mem_access(16'($urandom), 1'b1);
				2: io_write(16'($urandom), 8'($urandom), 1'b1);
				3: io_write(ports[$urandom_range(2, 0)], 8'($urandom), 1'b1);
				default: io_write(ports[$urandom_range(2, 0)], 8'($urandom), 1'b0); // Int ack
			endcase
		end
		@(negedge clk_sys);
		bus_idle();
	endtask

	initial begin
		void'($urandom(32'h32476ace));
		reset = 1'b1;
		model = spec_mem_pkg::MODEL_128;
		bus_idle();

		// ==============================
		// 128K paging and lock
		// ==============================
		enter_reset(spec_mem_pkg::MODEL_128);
		ula_write(8'h15);
		io_write(16'h7FFD, 8'h1F, 1'b1); // Bank 7, ROM 1, screen 1
		wait_scr_page(1'b1);
		sweep_slots();
		io_write(16'h7FFD, 8'h02, 1'b1);
		wait_scr_page(1'b0);
		sweep_slots();
		io_write(16'h7FFD, 8'h2C, 1'b1); // Locked
		wait_scr_page(1'b1);
		io_write(16'h7FFD, 8'h17, 1'b1);
		io_write(16'h1FFD, 8'h05, 1'b1);
		sweep_slots();
		random_cycles(200);

		// ==============================
		// +3 special and normal modes
		// ==============================
		enter_reset(spec_mem_pkg::MODEL_PLUS3);
		ula_write(8'h0A);
		for (int mode = 0; mode < 4; mode++) begin
			io_write(16'h1FFD, 8'(mode * 2 + 1), 1'b1);
			sweep_slots();
		end
		for (int rom = 0; rom < 4; rom++) begin
			io_write(16'h1FFD, {5'd0, rom[1], 2'd0}, 1'b1);
			io_write(16'h7FFD, {3'd0, rom[0], 1'b1, 3'(rom + 1)}, 1'b1);
			wait_scr_page(1'b1);
			sweep_slots();
		end
		io_write(16'h7FFD, 8'h20, 1'b1);
		io_write(16'h1FFD, 8'h01, 1'b1);
		sweep_slots();
		random_cycles(200);

		// 48K ignores paging
		enter_reset(spec_mem_pkg::MODEL_48);
		ula_write(8'h1F);
		io_write(16'h7FFD, 8'h17, 1'b1);
		io_write(16'h1FFD, 8'h07, 1'b1);
		sweep_slots();
		random_cycles(200);

		for (int i = 0; i < 6; i++) begin
			enter_reset(spec_mem_pkg::model_e'($urandom_range(2, 0)));
			random_cycles(150);
		end

		bus_idle();
		repeat (4) @(negedge clk_sys);
		if (dut0.u_asserts.fail_count != 0) begin
			stop_with_failure("a concurrent assertion failed");
		end else begin
			$display("** PASS **");
			$finish;
		end
	end

endmodule

// ==== spec_mem.f ====
src/spec_mem_pkg.sv
src/spec_port_pkg.sv
src/bus_control.sv
src/port_registers.sv
src/mem_mapper.sv
src/spec_mem_top.sv
bench/spec_mem_asserts.sv
bench/tb_spec_mem.sv

// ==== src/bus_control.sv ====
// Port decode for 7FFD, 1FFD and FE; one command per I/O write edge, no paging on 48K or when locked
module bus_control (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  spec_mem_pkg::model_e      model,
	input  spec_port_pkg::cpu_bus_t   bus,
	input  spec_port_pkg::page_state_t state,
	output spec_port_pkg::port_cmd_t  cmd,
	output spec_mem_pkg::model_e      cur_model
);

	spec_mem_pkg::model_e    model_q;
	spec_port_pkg::port_op_e op_q;
	spec_port_pkg::port_op_e op_next;
	logic [7:0]              data_q;
	logic                    io_wr;
	logic                    io_wr_q;
	logic                    plus3;
	logic                    paging_ok;
	logic                    sel_ula;
	logic                    sel_7ffd;
	logic                    sel_1ffd;

	// Model only changes across reset
	always_ff @(posedge clk_sys) begin
		if (reset)
			model_q <= model;
	end

	assign plus3 = (model_q == spec_mem_pkg::MODEL_PLUS3);

	// ==============================
	// Port decode
	// ==============================
	assign io_wr = ~bus.iorq_n & ~bus.wr_n & bus.m1_n; // Not int ack

	assign sel_ula  = ~bus.addr[0];
	assign sel_7ffd = ~bus.addr[15] & ~bus.addr[1] & bus.addr[0]
		& (bus.addr[14] | ~plus3); // +3 needs A14 high
	assign sel_1ffd = plus3 & (bus.addr[15:12] == 4'b0001) & ~bus.addr[1] & bus.addr[0];

	assign paging_ok = (model_q != spec_mem_pkg::MODEL_48)
		& ~state.p7ffd[spec_port_pkg::P7_LOCK_BIT];

	always_comb begin
		op_next = spec_port_pkg::OP_NONE;
		if (io_wr & ~io_wr_q) begin
			if (sel_ula)
				op_next = spec_port_pkg::OP_ULA;
			else if (sel_7ffd & paging_ok)
				op_next = spec_port_pkg::OP_7FFD;
			else if (sel_1ffd & paging_ok)
				op_next = spec_port_pkg::OP_1FFD;
		end
	end

	// ==============================
	// Command register
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
			op_q    <= spec_port_pkg::OP_NONE;
		end else begin
			io_wr_q <= io_wr;
			op_q    <= op_next; // One-cycle pulse
		end
	end

	always_ff @(posedge clk_sys) begin
		data_q <= bus.dout;
	end

	assign cmd.op     = op_q;
	assign cmd.data   = data_q;
	assign cur_model  = model_q;

endmodule

// ==== src/mem_mapper.sv ====
// CPU address to flat ROM/RAM address, purely combinational; assumes memory is always ready
module mem_mapper (
	input  spec_port_pkg::cpu_bus_t    bus,
	input  spec_port_pkg::page_state_t state,
	input  spec_mem_pkg::model_e       cur_model,
	output spec_mem_pkg::mem_req_t     mem,
	output logic                       scr_page
);

	logic [1:0]                          slot;
	logic [spec_mem_pkg::SLOT_OFS_W-1:0] ofs;
	logic                                plus3;
	logic                                special;
	logic [1:0]                          special_mode;
	logic [1:0]                          rom_num;
	logic [spec_mem_pkg::BANK_W-1:0]     bank;
	logic                                rom_sel;
	logic                                region;

	assign slot = bus.addr[15:14];
	assign ofs  = bus.addr[13:0];

	assign plus3        = (cur_model == spec_mem_pkg::MODEL_PLUS3);
	assign special      = plus3 & state.p1ffd[spec_port_pkg::P3_SPECIAL_BIT];
	assign special_mode = state.p1ffd[spec_port_pkg::P3_MODE_LSB +: 2];

	// ROM number per model
	always_comb begin
		case (cur_model)
			spec_mem_pkg::MODEL_128:
				rom_num = {1'b0, state.p7ffd[spec_port_pkg::P7_ROM_BIT]};
			spec_mem_pkg::MODEL_PLUS3:
				rom_num = {state.p1ffd[spec_port_pkg::P3_ROM_BIT],
					state.p7ffd[spec_port_pkg::P7_ROM_BIT]};
			default:
				rom_num = 2'b01; // 48K BASIC
		endcase
	end

	// ==============================
	// Slot to bank
	// ==============================
	always_comb begin
		rom_sel = 1'b0;
		if (special) begin
			bank = spec_mem_pkg::SPECIAL_MAP[special_mode][slot]; // All RAM
		end else begin
			case (slot)
				2'd0: begin
					bank    = {plus3, rom_num};
					rom_sel = 1'b1;
				end
				2'd1: bank = spec_mem_pkg::FIXED_BANK_SLOT1;
				2'd2: bank = spec_mem_pkg::FIXED_BANK_SLOT2;
				default: begin
					if (cur_model == spec_mem_pkg::MODEL_48)
						bank = '0;
					else
						bank = state.p7ffd[spec_port_pkg::P7_RAM_LSB +: spec_mem_pkg::BANK_W];
				end
			endcase
		end
	end

	assign region = rom_sel ? spec_mem_pkg::ROM_REGION : ~spec_mem_pkg::ROM_REGION;

	assign mem.addr = {region, bank, ofs};
	assign mem.rd   = ~bus.mreq_n & ~bus.rd_n;
	assign mem.we   = ~bus.mreq_n & ~bus.wr_n & ~rom_sel; // ROM is read only

	assign scr_page = state.p7ffd[spec_port_pkg::P7_SCR_BIT];

endmodule

// ==== src/port_registers.sv ====
// Paging and ULA latches; commands arrive pre-qualified, so lock and model are not checked here
module port_registers (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  spec_port_pkg::port_cmd_t   cmd,
	output spec_port_pkg::page_state_t state,
	output logic [2:0]                 border,
	output logic                       ear,
	output logic                       mic
);

	logic [7:0] p7ffd_q;
	logic [7:0] p1ffd_q;
	logic [2:0] border_q;
	logic       ear_q;
	logic       mic_q;

	// ==============================
	// Paging latches
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			p7ffd_q <= '0;
			p1ffd_q <= '0;
		end else begin
			case (cmd.op)
				spec_port_pkg::OP_7FFD: p7ffd_q <= cmd.data;
				spec_port_pkg::OP_1FFD: p1ffd_q <= cmd.data;
				default: ;
			endcase
		end
	end

	// ==============================
	// ULA port FE
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_q <= '0;
			ear_q    <= 1'b0;
			mic_q    <= 1'b0;
		end else if (cmd.op == spec_port_pkg::OP_ULA) begin
			border_q <= cmd.data[2:0];                     // Border colour
			ear_q    <= cmd.data[spec_port_pkg::ULA_EAR_BIT];
			mic_q    <= cmd.data[spec_port_pkg::ULA_MIC_BIT];
		end
	end

	assign state.p7ffd = p7ffd_q;
	assign state.p1ffd = p1ffd_q;

	assign border = border_q;
	assign ear    = ear_q;
	assign mic    = mic_q;

endmodule

// ==== src/spec_mem_pkg.sv ====
// Fixed 18-bit flat map of the 128K/+3 paging core with ROM at flat bit 17; no Pentagon/Profi banks
package spec_mem_pkg;

	// ==============================
	// Machine model
	// ==============================
	typedef enum logic [1:0] {
		MODEL_48,
		MODEL_128,
		MODEL_PLUS3
	} model_e;

	// ==============================
	// Flat address layout
	// ==============================
	// {region, bank, offset}
	localparam int FLAT_ADDR_W = 18;
	localparam int BANK_W      = 3;
	localparam int SLOT_OFS_W  = 14;

	localparam logic ROM_REGION = 1'b1; // Flat bit 17 for ROM

	// Normal mode RAM in 4000-7FFF and 8000-BFFF
	localparam logic [BANK_W-1:0] FIXED_BANK_SLOT1 = 3'd5;
	localparam logic [BANK_W-1:0] FIXED_BANK_SLOT2 = 3'd2;

	// +3 all-RAM layouts, indexed [mode][slot]
	// Mode 0: 0,1,2,3  mode 1: 4,5,6,7  mode 2: 4,5,6,3  mode 3: 4,7,6,3
	localparam logic [3:0][3:0][BANK_W-1:0] SPECIAL_MAP = {
		{3'd3, 3'd6, 3'd7, 3'd4}, // Mode 3
		{3'd3, 3'd6, 3'd5, 3'd4}, // Mode 2
		{3'd7, 3'd6, 3'd5, 3'd4}, // Mode 1
		{3'd3, 3'd2, 3'd1, 3'd0}  // Mode 0
	};

	// ==============================
	// Memory request
	// ==============================
	typedef struct packed {
		logic [FLAT_ADDR_W-1:0] addr;
		logic                   rd;
		logic                   we; // Already masked for ROM
	} mem_req_t;

endpackage

// ==== src/spec_mem_top.sv ====
// Paging core top; model is sampled only while reset is high, port writes land 2 cycles after the edge
module spec_mem_top (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  spec_mem_pkg::model_e    model,
	input  spec_port_pkg::cpu_bus_t bus,
	output spec_mem_pkg::mem_req_t  mem,
	output logic                    scr_page,
	output logic [2:0]              border,
	output logic                    ear,
	output logic                    mic
);

	spec_port_pkg::port_cmd_t   cmd;
	spec_port_pkg::page_state_t state;
	spec_mem_pkg::model_e       cur_model;

	// ==============================
	// Port decode and latches
	// ==============================
	bus_control u_bus_control (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.model     (model),
		.bus       (bus),
		.state     (state),     // Lock feedback
		.cmd       (cmd),
		.cur_model (cur_model)
	);

	port_registers u_port_registers (
		.clk_sys (clk_sys),
		.reset   (reset),
		.cmd     (cmd),
		.state   (state),
		.border  (border),
		.ear     (ear),
		.mic     (mic)
	);

	// ==============================
	// Address mapping
	// ==============================
	mem_mapper u_mem_mapper (
		.bus       (bus),
		.state     (state),
		.cur_model (cur_model),
		.mem       (mem),
		.scr_page  (scr_page)
	);

endmodule

// ==== src/spec_port_pkg.sv ====
// CPU bus and port types; bus strobes are active-low Z80 levels, data is the CPU output byte only
package spec_port_pkg;

	// ==============================
	// CPU bus as seen by the core
	// ==============================
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;   // CPU write data
		logic        mreq_n;
		logic        iorq_n;
		logic        rd_n;
		logic        wr_n;
		logic        m1_n;   // Low in opcode fetch and int ack
	} cpu_bus_t;

	// Decoded port write
	typedef enum logic [1:0] {
		OP_NONE,
		OP_7FFD,
		OP_1FFD,
		OP_ULA
	} port_op_e;

	typedef struct packed {
		port_op_e   op;
		logic [7:0] data;
	} port_cmd_t;

	// Paging latches
	typedef struct packed {
		logic [7:0] p7ffd;
		logic [7:0] p1ffd;
	} page_state_t;

	// ==============================
	// Register bit positions
	// ==============================
	// 7FFD
	localparam logic [2:0] P7_RAM_LSB  = 3'd0; // RAM bank in C000-FFFF, 3 bits
	localparam logic [2:0] P7_SCR_BIT  = 3'd3;
	localparam logic [2:0] P7_ROM_BIT  = 3'd4;
	localparam logic [2:0] P7_LOCK_BIT = 3'd5;

	// 1FFD
	localparam logic [2:0] P3_SPECIAL_BIT = 3'd0;
	localparam logic [2:0] P3_MODE_LSB    = 3'd1; // 2 bits
	localparam logic [2:0] P3_ROM_BIT     = 3'd2; // Shared with mode bit 1

	// FE
	localparam logic [2:0] ULA_MIC_BIT = 3'd3;
	localparam logic [2:0] ULA_EAR_BIT = 3'd4;

endpackage
